//--- Bender.yml
package:
  name: alu_issue_slot

sources:
  - common/alu_pkg.sv
  - hdl/operand_capture.sv
  - alu_station/alu_exec.sv
  - alu_station/alu_station.sv
  - hdl/alu_unit_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/alu_unit_tb.sv

//--- alu_station/alu_exec.sv
// ALU execution block with one-cycle logic and shift ops and an iterative shift-add multiplier
module alu_exec import alu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start_i,
	input  alu_op_e op_i,
	input  value_t arg_a_i,
	input  value_t arg_b_i,
	output logic done_o,
	output value_t result_o
);

	logic mul_busy;
	logic [MUL_CNT_BITS-1:0] mul_cnt;
	value_t acc_q;
	value_t mcand_q;
	value_t mplier_q;
	value_t step_acc;
	value_t step_mcand;
	value_t step_mplier;
	value_t alu_res;

	// ============================================================
	// Single-cycle operations
	// ============================================================
	always_comb begin
		case (op_i)
			ADD: alu_res = arg_a_i + arg_b_i;
			SUB: alu_res = arg_a_i - arg_b_i;
			AND: alu_res = arg_a_i & arg_b_i;
			OR:  alu_res = arg_a_i | arg_b_i;
			XOR: alu_res = arg_a_i ^ arg_b_i;
			SLL: alu_res = arg_a_i << arg_b_i[SHAMT_BITS-1:0];
			SRL: alu_res = arg_a_i >> arg_b_i[SHAMT_BITS-1:0];
			default: alu_res = '0;
		endcase
	end

	// ============================================================
	// Shift-add multiplier
	// ============================================================
	// The first step runs on the start edge straight from the arguments,
	// later steps run from the loop registers
	always_comb begin
		step_acc = mul_busy ? acc_q : '0;
		step_mcand = mul_busy ? mcand_q : arg_a_i;
		step_mplier = mul_busy ? mplier_q : arg_b_i;
		if (step_mplier[0])
			step_acc = step_acc + step_mcand;
	end

	// Control, the done pulse and the loop counter
	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
			mul_busy <= 1'b0;
			mul_cnt <= '0;
		end else begin
			done_o <= 1'b0;
			if (start_i && op_i != MUL) begin
				done_o <= 1'b1;
			end else if (start_i) begin
				mul_busy <= 1'b1;
				mul_cnt <= MUL_CNT_BITS'(MUL_CYCLES - 1);
			end else if (mul_busy) begin
				mul_cnt <= mul_cnt - 1'b1;
				// Counter at one means this edge performs the final step
				if (mul_cnt == 1) begin
					mul_busy <= 1'b0;
					done_o <= 1'b1;
				end
			end
		end
	end

	// Datapath registers, product bits above XLEN simply fall off the top
	always_ff @(posedge clk) begin
		if (start_i || mul_busy) begin
			acc_q <= step_acc;
			mcand_q <= step_mcand << 1;
			mplier_q <= step_mplier >> 1;
		end
		if (start_i && op_i != MUL)
			result_o <= alu_res;
		else if (mul_busy && mul_cnt == 1)
			result_o <= step_acc;
	end

	// The station holds one op, so a new start cannot overlap a multiply
	a_no_start_mul: assert property (@(posedge clk) disable iff (rst) !(start_i && mul_busy));
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o);

endmodule

//--- alu_station/alu_station.sv
// Single-entry ALU reservation station that gathers operands and launches or completes the op
module alu_station import alu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic issue_i,
	input  rob_ndx_t rob_ndx_i,
	input  instr_word_u instr_i,
	input  preg_t prs1_i,
	input  preg_t prs2_i,
	input  preg_t prd_i,
	input  logic copy_target_i,
	input  preg_t [RF_PORTS-1:0] rf_prn_i,
	input  logic [RF_PORTS-1:0] rf_prnv_i,
	input  value_t [RF_PORTS-1:0] rf_val_i,
	input  logic ex_done_i,
	input  value_t ex_result_i,
	output logic start_o,
	output alu_op_e op_o,
	output value_t arg_a_o,
	output value_t arg_b_o,
	output logic busy_o,
	output logic done_o,
	output rob_ndx_t done_ndx_o,
	output value_t result_o
);

	logic [1:0] state_q;
	logic cpy_done_q;
	logic issue_ok;
	rob_ndx_t rob_q;
	alu_op_e op_q;
	value_t imm_q;
	logic imm_form_q;
	logic copy_q;
	preg_t prs1_q;
	preg_t prs2_q;
	preg_t prd_q;
	value_t src1_val;
	value_t src2_val;
	value_t dst_val;
	logic src1_vld;
	logic src2_vld;
	logic dst_vld;
	logic ready;

	assign busy_o = state_q != ST_IDLE;
	assign issue_ok = issue_i && !busy_o;

	// ============================================================
	// Issue latch
	// ============================================================
	// The form bit is read through the register view, it is shared by both
	always_ff @(posedge clk) begin
		if (issue_ok) begin
			rob_q <= rob_ndx_i;
			op_q <= instr_i.r.op;
			imm_form_q <= instr_i.r.imm_form;
			imm_q <= {{(XLEN-IMM_BITS){instr_i.i.imm[IMM_BITS-1]}}, instr_i.i.imm};
			copy_q <= copy_target_i;
			prs1_q <= prs1_i;
			prs2_q <= prs2_i;
			prd_q <= prd_i;
		end
	end

	// Captures are cleared by the issue itself, so they start watching a cycle later
	operand_capture u_src1_cap (
		.clk(clk), .rst(rst), .clr_i(issue_ok), .preg_i(prs1_q),
		.rf_prn_i(rf_prn_i), .rf_prnv_i(rf_prnv_i), .rf_val_i(rf_val_i),
		.val_o(src1_val), .vld_o(src1_vld)
	);

	operand_capture u_src2_cap (
		.clk(clk), .rst(rst), .clr_i(issue_ok), .preg_i(prs2_q),
		.rf_prn_i(rf_prn_i), .rf_prnv_i(rf_prnv_i), .rf_val_i(rf_val_i),
		.val_o(src2_val), .vld_o(src2_vld)
	);

	// Old destination value, only waited for by copy-target ops
	operand_capture u_dst_cap (
		.clk(clk), .rst(rst), .clr_i(issue_ok), .preg_i(prd_q),
		.rf_prn_i(rf_prn_i), .rf_prnv_i(rf_prnv_i), .rf_val_i(rf_val_i),
		.val_o(dst_val), .vld_o(dst_vld)
	);

	// ============================================================
	// Operand readiness and launch
	// ============================================================
	// A copy-target needs only the old destination, other ops only their sources
	always_comb begin
		if (copy_q)
			ready = dst_vld;
		else
			ready = src1_vld && (src2_vld || imm_form_q);
	end

	assign start_o = state_q == ST_WAIT && ready && !copy_q;
	assign op_o = op_q;
	assign arg_a_o = src1_val;
	assign arg_b_o = imm_form_q ? imm_q : src2_val;

	// Completion comes from exec or from the station's own copy-target path
	assign done_o = ex_done_i || cpy_done_q;
	assign done_ndx_o = rob_q;
	assign result_o = cpy_done_q ? dst_val : ex_result_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			cpy_done_q <= 1'b0;
		end else begin
			cpy_done_q <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (issue_i)
						state_q <= ST_WAIT;
				end
				ST_WAIT: begin
					// Copy-target skips exec and signals done on the next edge
					if (ready) begin
						state_q <= ST_EXEC;
						cpy_done_q <= copy_q;
					end
				end
				default: begin
					if (done_o)
						state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// Upstream must respect busy, there is only the one entry
	a_no_issue_busy: assert property (@(posedge clk) disable iff (rst) !(issue_i && busy_o));
	// Exec must never report a result for an op the station did not hold
	a_done_busy: assert property (@(posedge clk) disable iff (rst) done_o |-> busy_o);

endmodule

//--- common/alu_pkg.sv
// ALU issue slot package with shared widths, opcodes, instruction word layout and constants
package alu_pkg;

	// ============================================================
	// Widths and scalar types
	// ============================================================
	localparam int XLEN = 32;
	localparam int PREG_BITS = 6;
	localparam int ROB_BITS = 5;
	localparam int RF_PORTS = 4;
	localparam int IMM_BITS = 16;
	// Shift amount comes from the low bits of operand B
	localparam int SHAMT_BITS = $clog2(XLEN);

	typedef logic [XLEN-1:0] value_t;
	typedef logic [PREG_BITS-1:0] preg_t;
	typedef logic [ROB_BITS-1:0] rob_ndx_t;

	// ============================================================
	// Opcodes and instruction word
	// ============================================================
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		SLL = 4'd5,
		SRL = 4'd6,
		MUL = 4'd7
	} alu_op_e;

	// Register form, operand B comes from the second source register
	typedef struct packed {
		alu_op_e op;
		logic imm_form;
		logic [4:0] func;
		logic [21:0] unused;
	} instr_reg_t;

	// Immediate form, operand B is the sign extended low half
	typedef struct packed {
		alu_op_e op;
		logic imm_form;
		logic [10:0] pad;
		logic [IMM_BITS-1:0] imm;
	} instr_imm_t;

	// Opcode and form bit sit at the same place in both views
	typedef union packed {
		instr_reg_t r;
		instr_imm_t i;
	} instr_word_u;

	// ============================================================
	// Multiplier and station FSM constants
	// ============================================================
	localparam int MUL_CYCLES = 32;
	localparam int MUL_CNT_BITS = $clog2(MUL_CYCLES);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_WAIT = 2'd1;
	localparam logic [1:0] ST_EXEC = 2'd2;

endpackage

//--- hdl/alu_unit_top.sv
// Integer ALU issue slot top level joining the reservation station and the execution block
module alu_unit_top import alu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic issue_i,
	input  rob_ndx_t rob_ndx_i,
	input  instr_word_u instr_i,
	input  preg_t prs1_i,
	input  preg_t prs2_i,
	input  preg_t prd_i,
	input  logic copy_target_i,
	input  preg_t [RF_PORTS-1:0] rf_prn_i,
	input  logic [RF_PORTS-1:0] rf_prnv_i,
	input  value_t [RF_PORTS-1:0] rf_val_i,
	output logic busy_o,
	output logic done_o,
	output rob_ndx_t done_ndx_o,
	output value_t result_o
);

	// Station to exec launch and return path
	logic ex_start;
	alu_op_e ex_op;
	value_t ex_arg_a;
	value_t ex_arg_b;
	logic ex_done;
	value_t ex_result;

	alu_station u_alu_station (
		.clk(clk), .rst(rst), .issue_i(issue_i), .rob_ndx_i(rob_ndx_i),
		.instr_i(instr_i), .prs1_i(prs1_i), .prs2_i(prs2_i), .prd_i(prd_i),
		.copy_target_i(copy_target_i), .rf_prn_i(rf_prn_i), .rf_prnv_i(rf_prnv_i),
		.rf_val_i(rf_val_i), .ex_done_i(ex_done), .ex_result_i(ex_result),
		.start_o(ex_start), .op_o(ex_op), .arg_a_o(ex_arg_a), .arg_b_o(ex_arg_b),
		.busy_o(busy_o), .done_o(done_o), .done_ndx_o(done_ndx_o), .result_o(result_o)
	);

	alu_exec u_alu_exec (
		.clk(clk), .rst(rst), .start_i(ex_start), .op_i(ex_op),
		.arg_a_i(ex_arg_a), .arg_b_i(ex_arg_b),
		.done_o(ex_done), .result_o(ex_result)
	);

endmodule

//--- hdl/operand_capture.sv
// Operand capture that snoops the register-file read ports for one physical register
module operand_capture import alu_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic clr_i,
	input  preg_t preg_i,
	input  preg_t [RF_PORTS-1:0] rf_prn_i,
	input  logic [RF_PORTS-1:0] rf_prnv_i,
	input  value_t [RF_PORTS-1:0] rf_val_i,
	output value_t val_o,
	output logic vld_o
);

	logic hit;
	value_t hit_val;

	// Fixed priority search, walking down so the lowest matching port is kept
	always_comb begin
		hit = 1'b0;
		hit_val = '0;
		for (int p = RF_PORTS - 1; p >= 0; p--) begin
			if (rf_prnv_i[p] && rf_prn_i[p] == preg_i) begin
				hit = 1'b1;
				hit_val = rf_val_i[p];
			end
		end
	end

	// Valid flag, sticky until the station clears it on the next issue
	always_ff @(posedge clk) begin
		if (rst || clr_i)
			vld_o <= 1'b0;
		else if (hit)
			vld_o <= 1'b1;
	end

	// Holding register only loads while the register is still missing
	always_ff @(posedge clk) begin
		if (!clr_i && !vld_o && hit)
			val_o <= hit_val;
	end

	// Once seen, an operand stays valid for the rest of the op
	a_vld_sticky: assert property (@(posedge clk) $fell(vld_o) |-> $past(clr_i || rst));

endmodule

//--- tests/alu_unit_tb.sv
// Testbench for the ALU issue slot with a register model, random operand timing and checks
module alu_unit_tb import alu_pkg::*; ();

	localparam int N_OPS = 48;
	localparam int MAX_DELAY = 6;
	localparam int MARGIN = 8;

	logic clk;
	logic rst;
	logic issue_i;
	rob_ndx_t rob_ndx_i;
	instr_word_u instr_i;
	preg_t prs1_i;
	preg_t prs2_i;
	preg_t prd_i;
	logic copy_target_i;
	preg_t [RF_PORTS-1:0] rf_prn_i;
	logic [RF_PORTS-1:0] rf_prnv_i;
	value_t [RF_PORTS-1:0] rf_val_i;
	logic busy_o;
	logic done_o;
	rob_ndx_t done_ndx_o;
	value_t result_o;

	// Reference state written by the stimulus and read by the checks
	int seed = 39;
	int cyc = 0;
	int exp_done_cyc = -1;
	value_t exp_result = '0;
	rob_ndx_t exp_ndx = '0;
	logic busy_exp = 1'b0;
	value_t regs [2**PREG_BITS];

	tb_clock u_tb_clock (.clk_o(clk), .rst_o(rst));

	alu_unit_top u_alu_unit_top (
		.clk(clk), .rst(rst), .issue_i(issue_i), .rob_ndx_i(rob_ndx_i),
		.instr_i(instr_i), .prs1_i(prs1_i), .prs2_i(prs2_i), .prd_i(prd_i),
		.copy_target_i(copy_target_i), .rf_prn_i(rf_prn_i), .rf_prnv_i(rf_prnv_i),
		.rf_val_i(rf_val_i), .busy_o(busy_o), .done_o(done_o),
		.done_ndx_o(done_ndx_o), .result_o(result_o)
	);

	// Cycle index where the cycle after edge n counts as cycle n
	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic int pick_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// A register number that none of the three operands of the op uses
	function automatic preg_t other_reg(input preg_t a, input preg_t b, input preg_t c);
		preg_t r;
		r = preg_t'($random(seed));
		while (r == a || r == b || r == c)
			r = r + 1'b1;
		return r;
	endfunction

	// Opcode semantics where multiply keeps the low XLEN bits of the product
	function automatic value_t model_result(input alu_op_e op, input value_t a, input value_t b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR:  return a | b;
			XOR: return a ^ b;
			SLL: return a << b[4:0];
			SRL: return a >> b[4:0];
			MUL: return a * b;
			default: return '0;
		endcase
	endfunction

	// ============================================================
	// Port stimulus
	// ============================================================
	// Every port gets a decoy that must never be taken as an operand
	task automatic fill_decoys(input preg_t rs1, input preg_t rs2, input preg_t rd);
		int r;
		for (int p = 0; p < RF_PORTS; p++) begin
			r = pick_below(3);
			rf_val_i[p] = $random(seed);
			case (pick_below(3))
				0: begin
					// Right register number but the valid bit is low
					rf_prn_i[p] = (r == 0) ? rs1 : (r == 1) ? rs2 : rd;
					rf_prnv_i[p] = 1'b0;
				end
				1: begin
					rf_prn_i[p] = other_reg(rs1, rs2, rd);
					rf_prnv_i[p] = 1'b1;
				end
				default: begin
					rf_prn_i[p] = preg_t'($random(seed));
					rf_prnv_i[p] = 1'b0;
				end
			endcase
		end
	endtask

	task automatic run_op(input alu_op_e op, input logic imm_form, input logic copy,
			input logic [IMM_BITS-1:0] imm);
		instr_word_u word;
		preg_t sel [3];
		logic need [3];
		int delay [3];
		logic [RF_PORTS-1:0] used;
		value_t b;
		int maxd;
		int k;
		int p;
		int q;
		logic seen;
		// Three distinct registers that each get a fresh producer value
		sel[0] = preg_t'($random(seed));
		sel[1] = sel[0] + preg_t'(1 + pick_below(62));
		sel[2] = other_reg(sel[0], sel[1], sel[1]);
		need[0] = !copy;
		need[1] = !copy && !imm_form;
		need[2] = copy;
		maxd = 0;
		for (int j = 0; j < 3; j++) begin
			regs[sel[j]] = $random(seed);
			delay[j] = pick_below(MAX_DELAY + 1);
			if (need[j] && delay[j] > maxd)
				maxd = delay[j];
		end
		b = imm_form ? {{(XLEN-IMM_BITS){imm[IMM_BITS-1]}}, imm} : regs[sel[1]];
		exp_result = copy ? regs[sel[2]] : model_result(op, regs[sel[0]], b);
		exp_ndx = rob_ndx_t'($random(seed));
		if (imm_form) begin
			word.i.op = op;
			word.i.imm_form = 1'b1;
			word.i.pad = 11'($random(seed));
			word.i.imm = imm;
		end else begin
			word.r.op = op;
			word.r.imm_form = 1'b0;
			word.r.func = 5'($random(seed));
			word.r.unused = 22'($random(seed));
		end

		// In the issue cycle the ports carry poisoned copies of every operand
		@(negedge clk);
		exp_done_cyc = cyc + 1 + maxd + ((op == MUL && !copy) ? MUL_CYCLES + 1 : 2);
		issue_i = 1'b1;
		rob_ndx_i = exp_ndx;
		instr_i = word;
		prs1_i = sel[0];
		prs2_i = sel[1];
		prd_i = sel[2];
		copy_target_i = copy;
		fill_decoys(sel[0], sel[1], sel[2]);
		for (int j = 0; j < 3; j++) begin
			rf_prn_i[j] = sel[j];
			rf_prnv_i[j] = 1'b1;
			rf_val_i[j] = ~regs[sel[j]];
		end

		k = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			issue_i = 1'b0;
			busy_exp = 1'b1;
			if (done_o) begin
				seen = 1'b1;
			end else begin
				fill_decoys(sel[0], sel[1], sel[2]);
				used = '0;
				for (int j = 0; j < 3; j++) begin
					// Arrival at its delay and now and then a stale repeat afterwards
					if (need[j] && (delay[j] == k || (delay[j] < k && pick_below(4) == 0))) begin
						do begin
							p = pick_below(RF_PORTS);
						end while (used[p]);
						used[p] = 1'b1;
						rf_prn_i[p] = sel[j];
						rf_prnv_i[p] = 1'b1;
						rf_val_i[p] = (delay[j] == k) ? regs[sel[j]] : ~regs[sel[j]];
						// A wrong copy on a higher port has to lose against port p
						q = p + 1 + pick_below(RF_PORTS);
						if (q < RF_PORTS && !used[q]) begin
							used[q] = 1'b1;
							rf_prn_i[q] = sel[j];
							rf_prnv_i[q] = 1'b1;
							rf_val_i[q] = regs[sel[j]] ^ 32'h5a5a_0001;
						end
					end
				end
				k++;
			end
		end
		@(negedge clk);
		busy_exp = 1'b0;
		rf_prnv_i = '0;
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial begin : stimulus
		logic [IMM_BITS-1:0] imm;
		issue_i = 1'b0;
		rob_ndx_i = '0;
		instr_i = '0;
		prs1_i = '0;
		prs2_i = '0;
		prd_i = '0;
		copy_target_i = 1'b0;
		rf_prn_i = '0;
		rf_prnv_i = '0;
		rf_val_i = '0;
		for (int r = 0; r < 2**PREG_BITS; r++)
			regs[r] = $random(seed);
		@(negedge rst);
		// Opcode, form and copy-target cycle at different rates so all mixes occur
		for (int i = 0; i < N_OPS; i++) begin
			imm = IMM_BITS'($random(seed));
			imm[IMM_BITS-1] = (i % 6) < 3;
			run_op(alu_op_e'(i % 8), (i % 3) == 1, (i % 5) == 4, imm);
		end
		$display("Simulation passed");
		$finish;
	end

	initial begin
		#((N_OPS * (MUL_CYCLES + MAX_DELAY + MARGIN) + 20) * 10);
		stop_on_error("Watchdog expired before every op reported completion");
	end

	// ============================================================
	// Checks
	// ============================================================
	a_reset_quiet: assert property (@(posedge clk) rst |=> !done_o && !busy_o)
		else stop_on_error($sformatf("[ERROR] %0t done_o,busy_o expected 00 got %b%b",
			$time, $sampled(done_o), $sampled(busy_o)));

	a_busy: assert property (@(posedge clk) disable iff (rst) busy_o == busy_exp)
		else stop_on_error($sformatf("[ERROR] %0t busy_o expected %b got %b",
			$time, busy_exp, $sampled(busy_o)));

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_o |=> !done_o)
		else stop_on_error($sformatf("[ERROR] %0t done_o expected 0 got %b",
			$time, $sampled(done_o)));

	// Completion must land in the cycle given by the operand arrival and the op latency
	a_done_cycle: assert property (@(posedge clk) disable iff (rst)
		done_o |-> cyc == exp_done_cyc)
		else stop_on_error($sformatf("[ERROR] %0t done_o cycle expected %0d got %0d",
			$time, exp_done_cyc, $sampled(cyc)));

	a_done_ndx: assert property (@(posedge clk) disable iff (rst)
		done_o |-> done_ndx_o == exp_ndx)
		else stop_on_error($sformatf("[ERROR] %0t done_ndx_o expected %0d got %0d",
			$time, exp_ndx, $sampled(done_ndx_o)));

	a_result: assert property (@(posedge clk) disable iff (rst)
		done_o |-> result_o == exp_result)
		else stop_on_error($sformatf("[ERROR] %0t result_o expected %h got %h",
			$time, exp_result, $sampled(result_o)));

endmodule

//--- tests/tb_clock.sv
// Testbench clock and reset source with a 10 unit period and a 10 cycle reset
module tb_clock (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Reset is released on a falling edge, away from the sampling edge
	initial begin
		rst_o = 1'b1;
		repeat (10) @(posedge clk_o);
		@(negedge clk_o);
		rst_o = 1'b0;
	end

endmodule

//--- verilog.f
common/alu_pkg.sv
hdl/operand_capture.sv
alu_station/alu_exec.sv
alu_station/alu_station.sv
hdl/alu_unit_top.sv
tests/tb_clock.sv
tests/alu_unit_tb.sv
